/* verilog/vdma_write_pkg.sv */
// shared widths, pixel and beat types, request and aw structs, writer and planner state enums
package vdma_write_pkg;

    // native video pixel width
    localparam int PIX_W = 32;
    // memory data bus width
    localparam int BEAT_W = 128;
    // pixels gathered into one memory beat
    localparam int PIX_PER_BEAT = BEAT_W / PIX_W;
    // byte span of one beat on the bus
    localparam int BEAT_BYTES = BEAT_W / 8;

    // one video pixel
    typedef logic [PIX_W-1:0] pixel_t;
    // one packed beat, pixel k in bits 32k upward
    typedef logic [BEAT_W-1:0] beat_t;
    // byte address
    typedef logic [31:0] addr_t;
    // beats minus one, same as awlen
    typedef logic [7:0] len_t;
    // fifo fill level and line beat counts
    typedef logic [15:0] count_t;

    // planner to writer request
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } burst_req_t;

    // aw channel payload on the top ports
    typedef struct packed {
        addr_t awaddr;
        len_t  awlen;
    } axi_aw_t;

    // write core phases
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } writer_state_t;

    // burst planner phases
    typedef enum logic [1:0] {
        PL_WAIT_DATA,
        PL_REQUEST,
        PL_WAIT_DONE
    } planner_state_t;

endpackage

/* verilog/pixel_packer.sv */
// pixel_packer: vsync rise detection and four-pixel beat packing
module pixel_packer (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   vsync,
    input  logic                   de,
    input  vdma_write_pkg::pixel_t pixel,
    output logic                   beat_valid,
    output vdma_write_pkg::beat_t  beat,
    output logic                   frame_start
);

    localparam int SLOT_W = $clog2(vdma_write_pkg::PIX_PER_BEAT);
    // index of the pixel that closes a beat
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(vdma_write_pkg::PIX_PER_BEAT - 1);

    logic              vsync_d;
    logic              vsync_rise;
    logic [SLOT_W-1:0] slot;
    logic [SLOT_W-1:0] slot_base;

    // low to high on the sampled vsync
    assign vsync_rise = vsync && !vsync_d;

    // a new frame always begins at slot 0,
    // even if de is already high on the rise cycle
    assign slot_base = vsync_rise ? '0 : slot;

    // control side
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            vsync_d     <= 1'b0;
            frame_start <= 1'b0;
            slot        <= '0;
            beat_valid  <= 1'b0;
        end else begin
            vsync_d     <= vsync;
            // one cycle pulse, registered from the edge
            frame_start <= vsync_rise;
            beat_valid  <= 1'b0;
            if (de) begin
                // wraps back to 0 after the last slot
                slot <= slot_base + 1'b1;
                if (slot_base == LAST_SLOT) begin
                    beat_valid <= 1'b1;
                end
            end else begin
                slot <= slot_base;
            end
        end
    end

    // shift register for the beat payload
    // new pixel enters at the top, so after four shifts
    // the first pixel of the group sits in the low bits
    always_ff @(posedge clock) begin
        if (de) begin
            beat <= {pixel, beat[vdma_write_pkg::BEAT_W-1:vdma_write_pkg::PIX_W]};
        end
    end

endmodule

/* verilog/beat_fifo.sv */
// beat_fifo: synchronous first-word-fall-through beat buffer with fill count
module beat_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   push,
    input  vdma_write_pkg::beat_t  din,
    input  logic                   pop,
    output vdma_write_pkg::beat_t  head,
    output vdma_write_pkg::count_t count,
    output logic                   almost_full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

    // storage, no reset on the data
    vdma_write_pkg::beat_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == vdma_write_pkg::count_t'(FIFO_DEPTH));
    // a strobe into a full buffer is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && (count != '0);

    // head falls through from the read pointer
    assign head = mem[rd_ptr];

    // advisory only, the video side has no stall
    assign almost_full = (count >= vdma_write_pkg::count_t'(FIFO_DEPTH - 4));

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap explicitly so any depth works
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // fill level
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/burst_planner.sv */
// burst_planner: line to burst split, burst and line address tracking
module burst_planner #(
    parameter int BURST_LEN = 16,
    parameter int LINE_STEP = 4096
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       enable,
    input  vdma_write_pkg::addr_t      baseaddr,
    input  vdma_write_pkg::count_t     hactive,
    input  logic                       frame_start,
    input  vdma_write_pkg::count_t     count,
    input  logic                       req_resp,
    input  logic                       req_done,
    output logic                       burst_req,
    output vdma_write_pkg::burst_req_t req
);

    vdma_write_pkg::planner_state_t state;

    // beats still to be requested in the current line
    vdma_write_pkg::count_t remain;
    // first byte of the current line
    vdma_write_pkg::addr_t  line_addr;
    // address of the next burst
    vdma_write_pkg::addr_t  next_addr;

    vdma_write_pkg::count_t line_beats;
    vdma_write_pkg::count_t cur_len;
    vdma_write_pkg::addr_t  burst_bytes;
    vdma_write_pkg::addr_t  next_line;
    logic                   issue;

    // hactive is a multiple of four pixels
    assign line_beats = hactive / vdma_write_pkg::count_t'(vdma_write_pkg::PIX_PER_BEAT);

    // full burst or the line tail
    assign cur_len = (remain >= vdma_write_pkg::count_t'(BURST_LEN))
                   ? vdma_write_pkg::count_t'(BURST_LEN) : remain;

    assign burst_bytes = vdma_write_pkg::addr_t'(cur_len)
                       * vdma_write_pkg::addr_t'(vdma_write_pkg::BEAT_BYTES);

    assign next_line = line_addr + vdma_write_pkg::addr_t'(LINE_STEP);

    // request only with the whole burst already buffered,
    // so the writer never runs dry mid-burst
    // a frame start in the same cycle wins and delays the request
    assign issue = (state == vdma_write_pkg::PL_WAIT_DATA) && enable && !frame_start
                && (remain != '0) && (count >= cur_len);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= vdma_write_pkg::PL_WAIT_DATA;
            burst_req <= 1'b0;
            remain    <= '0;
            line_addr <= '0;
            next_addr <= '0;
        end else begin
            // address bookkeeping, done at issue time
            if (frame_start) begin
                line_addr <= baseaddr;
                next_addr <= baseaddr;
                remain    <= line_beats;
            end else if (issue) begin
                if (remain == cur_len) begin
                    // tail of the line, step to the next line
                    line_addr <= next_line;
                    next_addr <= next_line;
                    remain    <= line_beats;
                end else begin
                    next_addr <= next_addr + burst_bytes;
                    remain    <= remain - cur_len;
                end
            end

            // handshake with the writer
            case (state)
                vdma_write_pkg::PL_WAIT_DATA: begin
                    if (issue) begin
                        burst_req <= 1'b1;
                        state     <= vdma_write_pkg::PL_REQUEST;
                    end
                end
                vdma_write_pkg::PL_REQUEST: begin
                    // held until the address is accepted
                    if (req_resp) begin
                        burst_req <= 1'b0;
                        state     <= vdma_write_pkg::PL_WAIT_DONE;
                    end
                end
                vdma_write_pkg::PL_WAIT_DONE: begin
                    if (req_done) begin
                        state <= vdma_write_pkg::PL_WAIT_DATA;
                    end
                end
                default: state <= vdma_write_pkg::PL_WAIT_DATA;
            endcase
        end
    end

    // request payload, steady while burst_req is high
    always_ff @(posedge clock) begin
        if (issue) begin
            req.addr <= next_addr;
            req.len  <= vdma_write_pkg::len_t'(cur_len - 1'b1);
        end
    end

endmodule

/* verilog/axi_burst_writer.sv */
// axi_burst_writer: aw, w and b phase FSM for one outstanding burst
module axi_burst_writer (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       burst_req,
    input  vdma_write_pkg::burst_req_t req,
    input  vdma_write_pkg::beat_t      head,
    output logic                       pop,
    output logic                       req_resp,
    output logic                       req_done,
    output vdma_write_pkg::axi_aw_t    axi_aw,
    output logic                       awvalid,
    input  logic                       awready,
    output vdma_write_pkg::beat_t      wdata,
    output logic                       wlast,
    output logic                       wvalid,
    input  logic                       wready,
    input  logic                       bvalid,
    output logic                       bready
);

    vdma_write_pkg::writer_state_t state;

    // beats left after the current one
    vdma_write_pkg::len_t beat_cnt;

    // channel handshakes follow the state directly
    assign awvalid = (state == vdma_write_pkg::WR_ADDR);
    assign wvalid  = (state == vdma_write_pkg::WR_DATA);
    assign bready  = (state == vdma_write_pkg::WR_RESP);
    assign wlast   = wvalid && (beat_cnt == '0);

    // data comes straight off the fifo head
    assign wdata = head;
    // every accepted beat leaves the fifo
    assign pop   = wvalid && wready;

    // one cycle strobe on the aw handshake
    assign req_resp = awvalid && awready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= vdma_write_pkg::WR_IDLE;
            beat_cnt <= '0;
            req_done <= 1'b0;
        end else begin
            req_done <= 1'b0;
            case (state)
                vdma_write_pkg::WR_IDLE: begin
                    if (burst_req) begin
                        beat_cnt <= req.len;
                        state    <= vdma_write_pkg::WR_ADDR;
                    end
                end
                vdma_write_pkg::WR_ADDR: begin
                    if (awready) begin
                        state <= vdma_write_pkg::WR_DATA;
                    end
                end
                vdma_write_pkg::WR_DATA: begin
                    // stalls in place while wready is low
                    if (wready) begin
                        if (beat_cnt == '0) begin
                            state <= vdma_write_pkg::WR_RESP;
                        end else begin
                            beat_cnt <= beat_cnt - 1'b1;
                        end
                    end
                end
                vdma_write_pkg::WR_RESP: begin
                    // bresp not checked
                    if (bvalid) begin
                        req_done <= 1'b1;
                        state    <= vdma_write_pkg::WR_IDLE;
                    end
                end
                default: state <= vdma_write_pkg::WR_IDLE;
            endcase
        end
    end

    // aw payload latched with the request
    always_ff @(posedge clock) begin
        if ((state == vdma_write_pkg::WR_IDLE) && burst_req) begin
            axi_aw.awaddr <= req.addr;
            axi_aw.awlen  <= req.len;
        end
    end

endmodule

/* verilog/vdma_write.sv */
// vdma_write: top level with packer, beat fifo, burst planner and axi writer
module vdma_write #(
    parameter int BURST_LEN  = 16,
    parameter int LINE_STEP  = 4096,
    parameter int FIFO_DEPTH = 64
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    enable,
    input  vdma_write_pkg::addr_t   baseaddr,
    input  vdma_write_pkg::count_t  hactive,
    input  logic                    vsync,
    input  logic                    de,
    input  vdma_write_pkg::pixel_t  pixel,
    output logic                    fifo_almost_full,
    output vdma_write_pkg::axi_aw_t axi_aw,
    output logic                    awvalid,
    input  logic                    awready,
    output vdma_write_pkg::beat_t   wdata,
    output logic                    wlast,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    bready
);

    // packer to fifo
    logic                       beat_valid;
    vdma_write_pkg::beat_t      beat;
    logic                       frame_start;
    // fifo to planner and writer
    vdma_write_pkg::beat_t      head;
    vdma_write_pkg::count_t     count;
    logic                       pop;
    // planner to writer strobes
    logic                       burst_req;
    vdma_write_pkg::burst_req_t req;
    logic                       req_resp;
    logic                       req_done;

    pixel_packer u_packer (
        .clock       (clock),
        .rst_n       (rst_n),
        .vsync       (vsync),
        .de          (de),
        .pixel       (pixel),
        .beat_valid  (beat_valid),
        .beat        (beat),
        .frame_start (frame_start)
    );

    beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clock       (clock),
        .rst_n       (rst_n),
        .push        (beat_valid),
        .din         (beat),
        .pop         (pop),
        .head        (head),
        .count       (count),
        .almost_full (fifo_almost_full)
    );

    burst_planner #(
        .BURST_LEN (BURST_LEN),
        .LINE_STEP (LINE_STEP)
    ) u_planner (
        .clock       (clock),
        .rst_n       (rst_n),
        .enable      (enable),
        .baseaddr    (baseaddr),
        .hactive     (hactive),
        .frame_start (frame_start),
        .count       (count),
        .req_resp    (req_resp),
        .req_done    (req_done),
        .burst_req   (burst_req),
        .req         (req)
    );

    axi_burst_writer u_writer (
        .clock     (clock),
        .rst_n     (rst_n),
        .burst_req (burst_req),
        .req       (req),
        .head      (head),
        .pop       (pop),
        .req_resp  (req_resp),
        .req_done  (req_done),
        .axi_aw    (axi_aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

endmodule

/* test/tb_clock.sv */
// tb_clock: free running testbench clock
module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    // half period high, half low
    always #(PERIOD / 2) clock = ~clock;

endmodule

/* test/vdma_write_checker.sv */
// vdma_write_checker: AXI write channel protocol assertions bound to the top level
module vdma_write_checker (
    input logic                    clock,
    input logic                    rst_n,
    input vdma_write_pkg::axi_aw_t axi_aw,
    input logic                    awvalid,
    input logic                    awready,
    input logic                    wvalid,
    input logic                    wlast,
    input logic                    wready,
    input logic                    bvalid,
    input logic                    bready
);

    // failed assertion count, read by the testbench top
    int   fails = 0;
    // between aw handshake and wlast handshake
    logic in_burst;
    // between aw handshake and b handshake
    logic resp_owed;
    int   aw_cnt;
    int   wl_cnt;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            in_burst  <= 1'b0;
            resp_owed <= 1'b0;
            aw_cnt    <= 0;
            wl_cnt    <= 0;
        end else begin
            if (awvalid && awready) begin
                in_burst  <= 1'b1;
                resp_owed <= 1'b1;
                aw_cnt    <= aw_cnt + 1;
            end
            if (wvalid && wready && wlast) begin
                in_burst <= 1'b0;
                wl_cnt   <= wl_cnt + 1;
            end
            if (bvalid && bready) begin
                resp_owed <= 1'b0;
            end
        end
    end

    // address and payload held until accepted
    aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(axi_aw))
        else begin
            $error("aw channel dropped or changed before awready");
            fails++;
        end

    // data only inside an accepted burst
    w_in_burst: assert property (@(posedge clock) disable iff (!rst_n)
        wvalid |-> in_burst)
        else begin
            $error("wvalid outside a burst");
            fails++;
        end

    // a single burst in flight
    one_outstanding: assert property (@(posedge clock) disable iff (!rst_n)
        awvalid |-> !resp_owed)
        else begin
            $error("second awvalid before the write response");
            fails++;
        end

    // every accepted address ends in exactly one wlast
    wlast_count: assert property (@(posedge clock) disable iff (!rst_n)
        (bvalid && bready) |-> (wl_cnt == aw_cnt))
        else begin
            $error("wlast count differs from aw count");
            fails++;
        end

    wlast_order: assert property (@(posedge clock) disable iff (!rst_n)
        wl_cnt <= aw_cnt)
        else begin
            $error("wlast seen without a matching address");
            fails++;
        end

endmodule

/* test/vdma_write_monitor.sv */
// vdma_write_monitor: reference model of packing, burst split and addresses, output compare
module vdma_write_monitor #(
    parameter int BURST_LEN  = 16,
    parameter int LINE_STEP  = 4096,
    parameter int FIFO_DEPTH = 64
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    enable,
    input  vdma_write_pkg::addr_t   baseaddr,
    input  vdma_write_pkg::count_t  hactive,
    input  logic                    vsync,
    input  logic                    de,
    input  vdma_write_pkg::pixel_t  pixel,
    input  logic                    fifo_almost_full,
    input  vdma_write_pkg::axi_aw_t axi_aw,
    input  logic                    awvalid,
    input  logic                    awready,
    input  vdma_write_pkg::beat_t   wdata,
    input  logic                    wlast,
    input  logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    input  logic                    bready,
    input  int                      test_id,
    input  logic                    test_end,
    output logic                    idle,
    output int                      checks,
    output int                      errors
);

    localparam int PPB = 4;
    localparam int BYTES_PER_BEAT = 16;

    // expected beats in write order
    vdma_write_pkg::beat_t  exp_q [$];
    vdma_write_pkg::pixel_t group [PPB];
    int                     pix_n;
    logic                   vsync_q;
    // line and burst position of the model
    vdma_write_pkg::addr_t  line_addr;
    int                     remain;
    int                     offset;
    int                     beats_left;
    logic                   burst_open;
    // model of the fifo fill level
    int                     fill;
    logic                   push_p1;
    logic                   push_p2;
    logic                   pop_p1;
    // per test bookkeeping
    int                     bursts;
    int                     beats;
    int                     mark_bursts;
    int                     mark_beats;
    int                     mark_errors;

    initial begin
        idle        = 1'b1;
        checks      = 0;
        errors      = 0;
        pix_n       = 0;
        vsync_q     = 1'b0;
        line_addr   = '0;
        remain      = 0;
        offset      = 0;
        beats_left  = 0;
        burst_open  = 1'b0;
        fill        = 0;
        push_p1     = 1'b0;
        push_p2     = 1'b0;
        pop_p1      = 1'b0;
        bursts      = 0;
        beats       = 0;
        mark_bursts = 0;
        mark_beats  = 0;
        mark_errors = 0;
    end

    // pixel 0 of the group in the low bits
    function automatic vdma_write_pkg::beat_t pack_group();
        vdma_write_pkg::beat_t b;
        for (int k = 0; k < PPB; k++) begin
            b[k*32 +: 32] = group[k];
        end
        return b;
    endfunction

    task automatic compare(input string what, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic fail_plain(input string msg);
        checks++;
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // burst length and address from the split rule
    task automatic check_aw();
        int cur;
        cur = (remain >= BURST_LEN) ? BURST_LEN : remain;
        if (cur == 0) begin
            fail_plain("burst address issued with no beats left in the line");
        end else begin
            compare("awaddr", axi_aw.awaddr, line_addr + offset * BYTES_PER_BEAT);
            compare("awlen", axi_aw.awlen, cur - 1);
            if (remain == cur) begin
                // tail burst closes the line
                line_addr = line_addr + LINE_STEP;
                remain    = hactive / PPB;
                offset    = 0;
            end else begin
                offset = offset + cur;
                remain = remain - cur;
            end
        end
        beats_left = cur;
        burst_open = 1'b1;
        bursts++;
    endtask

    task automatic check_w();
        if (beats_left == 0) begin
            fail_plain("write beat accepted outside an open burst");
        end else if (exp_q.size() == 0) begin
            fail_plain("write beat accepted with no pixels left to send");
        end else begin
            compare("wdata", wdata, exp_q.pop_front());
            compare("wlast", wlast, beats_left == 1);
            beats_left--;
        end
        beats++;
    endtask

    task automatic report_test();
        $display("test %0d done: %0d bursts, %0d beats, %0d errors", test_id,
                 bursts - mark_bursts, beats - mark_beats, errors - mark_errors);
        mark_bursts = bursts;
        mark_beats  = beats;
        mark_errors = errors;
    endtask

    // falling edge sees what the next rising edge samples
    always @(negedge clock) begin
        if (!rst_n) begin
            vsync_q = 1'b0;
            pix_n   = 0;
            fill    = 0;
            push_p1 = 1'b0;
            push_p2 = 1'b0;
            pop_p1  = 1'b0;
        end else begin
            // fill level lags a group by two edges and a pop by one
            if (push_p2) begin
                fill++;
            end
            if (pop_p1) begin
                fill--;
            end
            push_p2 = push_p1;
            push_p1 = 1'b0;
            if (vsync && !vsync_q) begin
                // frame restart at the current base
                line_addr = baseaddr;
                remain    = hactive / PPB;
                offset    = 0;
                pix_n     = 0;
            end
            vsync_q = vsync;
            if (de) begin
                group[pix_n] = pixel;
                pix_n++;
                if (pix_n == PPB) begin
                    exp_q.push_back(pack_group());
                    push_p1 = 1'b1;
                    pix_n   = 0;
                end
            end
            compare("almost_full", fifo_almost_full, fill >= FIFO_DEPTH - 4);
            if (awvalid && !enable) begin
                fail_plain("awvalid raised while enable is low");
            end
            if (awvalid && awready) begin
                check_aw();
            end
            if (wvalid && wready) begin
                check_w();
            end
            pop_p1 = wvalid && wready;
            if (bvalid && bready) begin
                burst_open = 1'b0;
            end
            if (test_end) begin
                report_test();
            end
            idle = (exp_q.size() == 0) && !burst_open;
        end
    end

endmodule

/* test/tb_vdma_write.sv */
// tb_vdma_write: testbench top with video source, AXI slave, tests and summary
module tb_vdma_write;

    localparam int BURST_LEN = 16;
    localparam int LINE_STEP = 4096;
    // small enough that the held frame of test 4 crosses almost full
    localparam int FIFO_DEPTH = 32;
    // pixel cycles of all four frames
    localparam int PIX_CYCLES = 4 * 72 + 3 * 40 + 4 * 72 + 3 * 40;
    localparam int CYCLE_LIMIT = 4 * PIX_CYCLES + 2000;
    localparam int NUM_TESTS = 4;

    logic                    clock;
    logic                    rst_n;
    logic                    enable;
    vdma_write_pkg::addr_t   baseaddr;
    vdma_write_pkg::count_t  hactive;
    logic                    vsync;
    logic                    de;
    vdma_write_pkg::pixel_t  pixel;
    logic                    fifo_almost_full;
    vdma_write_pkg::axi_aw_t axi_aw;
    logic                    awvalid;
    logic                    awready;
    vdma_write_pkg::beat_t   wdata;
    logic                    wlast;
    logic                    wvalid;
    logic                    wready;
    logic                    bvalid;
    logic                    bready;

    // monitor side
    int                      test_id;
    logic                    test_end;
    logic                    idle;
    int                      checks;
    int                      errors;

    // slave state and random source
    logic [31:0]             seed;
    logic                    stall;
    logic                    b_owed;
    int                      b_delay;
    int                      cycles;
    int                      total_errors;

    tb_clock #(
        .PERIOD (4)
    ) u_clock (
        .clock (clock)
    );

    vdma_write #(
        .BURST_LEN  (BURST_LEN),
        .LINE_STEP  (LINE_STEP),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (.*);

    vdma_write_monitor #(
        .BURST_LEN  (BURST_LEN),
        .LINE_STEP  (LINE_STEP),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_monitor (.*);

    bind vdma_write vdma_write_checker u_checker (.*);

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // upper bits only, the low ones cycle quickly
    function automatic int rand_below(input int n);
        return int'((next_rand() >> 16) % n);
    endfunction

    // one clock, inputs change 1 unit after the rising edge
    // the AXI slave side is updated here as well
    task automatic step();
        logic last_hs;
        logic b_hs;
        @(negedge clock);
        last_hs = wvalid && wready && wlast;
        b_hs    = bvalid && bready;
        @(posedge clock);
        #1;
        if (b_hs) begin
            bvalid = 1'b0;
        end
        if (last_hs) begin
            b_owed  = 1'b1;
            b_delay = stall ? rand_below(5) : 0;
        end
        if (b_owed && !bvalid) begin
            if (b_delay == 0) begin
                bvalid = 1'b1;
                b_owed = 1'b0;
            end else begin
                b_delay--;
            end
        end
        awready = stall ? (rand_below(4) != 0) : 1'b1;
        wready  = stall ? (rand_below(3) != 0) : 1'b1;
    endtask

    // vsync pulse, then lines with random pixels and gaps
    task automatic send_frame(input int hact, input int lines);
        vsync = 1'b1;
        step();
        step();
        vsync = 1'b0;
        repeat (4) step();
        for (int l = 0; l < lines; l++) begin
            for (int p = 0; p < hact; p++) begin
                de    = 1'b1;
                pixel = next_rand();
                step();
            end
            de    = 1'b0;
            pixel = '0;
            repeat (3 + rand_below(8)) step();
        end
    endtask

    task automatic run_test(input int id, input vdma_write_pkg::addr_t base, input int hact,
                            input int lines, input logic use_stall, input logic en);
        test_id  = id;
        stall    = use_stall;
        enable   = en;
        baseaddr = base;
        hactive  = vdma_write_pkg::count_t'(hact);
        send_frame(hact, lines);
        if (!en) begin
            // beats pile up in the FIFO, nothing may go out
            repeat (20) step();
            enable = 1'b1;
        end
        // all beats written and the last response taken
        while (!idle) begin
            step();
        end
        test_end = 1'b1;
        step();
        test_end = 1'b0;
    endtask

    // run limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed     = 32'h8b6e;
        rst_n    = 1'b0;
        enable   = 1'b1;
        baseaddr = '0;
        hactive  = '0;
        vsync    = 1'b0;
        de       = 1'b0;
        pixel    = '0;
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        stall    = 1'b0;
        b_owed   = 1'b0;
        b_delay  = 0;
        test_id  = 0;
        test_end = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // 72 pixels per line, 16 beat bursts plus a 2 beat tail
        run_test(1, 32'h1000_0000, 72, 4, 1'b0, 1'b1);
        // new base on the next vsync
        run_test(2, 32'h2000_0000, 40, 3, 1'b0, 1'b1);
        run_test(3, 32'h3000_0000, 72, 4, 1'b1, 1'b1);
        // writes held off, then released
        run_test(4, 32'h4000_0000, 40, 3, 1'b1, 1'b0);

        total_errors = errors + uut.u_checker.fails;
        $display("summary: %0d tests, %0d checks, %0d compare errors, %0d assertion failures",
                 NUM_TESTS, checks, errors, uut.u_checker.fails);
        if (total_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vdma_write.f */
verilog/vdma_write_pkg.sv
verilog/pixel_packer.sv
verilog/beat_fifo.sv
verilog/burst_planner.sv
verilog/axi_burst_writer.sv
verilog/vdma_write.sv
test/tb_clock.sv
test/vdma_write_checker.sv
test/vdma_write_monitor.sv
test/tb_vdma_write.sv

/* Bender.yml */
package:
  name: vdma_write

sources:
  - verilog/vdma_write_pkg.sv
  - verilog/pixel_packer.sv
  - verilog/beat_fifo.sv
  - verilog/burst_planner.sv
  - verilog/axi_burst_writer.sv
  - verilog/vdma_write.sv
  - target: simulation
    files:
      - test/tb_clock.sv
      - test/vdma_write_checker.sv
      - test/vdma_write_monitor.sv
      - test/tb_vdma_write.sv
